// File: scc_pkg.sv
`default_nettype none

package scc_pkg;

	// cpu side access, one clk strobe
	typedef struct packed {
		logic       cs;    // chip select strobe
		logic       we;    // write flag
		logic [1:0] rs;    // [1] data/ctl, [0] a/b side
		logic [7:0] wdata;
	} scc_bus_t;

	// per channel config seen by status and irq logic
	typedef struct packed {
		logic [7:0] wr1;
		logic       rx_en; // wr3 bit 0
		logic [7:0] wr15;
	} scc_chan_cfg_t;

	// same order as rr3 bits 5..0
	typedef struct packed {
		logic rx_a;
		logic tx_a;
		logic ext_a;
		logic rx_b;
		logic tx_b;
		logic ext_b;
	} scc_pend_t;

	parameter int REG_PTR_W = 4;

	parameter logic [REG_PTR_W-1:0] REG_WR0   = 4'd0;
	parameter logic [REG_PTR_W-1:0] REG_WR1   = 4'd1;
	parameter logic [REG_PTR_W-1:0] REG_WR2   = 4'd2;
	parameter logic [REG_PTR_W-1:0] REG_WR3   = 4'd3;
	parameter logic [REG_PTR_W-1:0] REG_DATA  = 4'd8;  // data alias on read
	parameter logic [REG_PTR_W-1:0] REG_WR9   = 4'd9;
	parameter logic [REG_PTR_W-1:0] REG_RR15B = 4'd11; // rr15 alias
	parameter logic [REG_PTR_W-1:0] REG_WR15  = 4'd15;

	// wr0 bits 5..3
	parameter logic [2:0] CMD_POINT_HIGH  = 3'b001;
	parameter logic [2:0] CMD_RESET_EXT   = 3'b010;
	parameter logic [2:0] CMD_RESET_TX_IP = 3'b101;

	// wr9 bits 7..6
	parameter logic [1:0] RST_FULL   = 2'b11;
	parameter logic [1:0] RST_CHAN_A = 2'b10;
	parameter logic [1:0] RST_CHAN_B = 2'b01;

	parameter logic [7:0] WR15_RESET = 8'hf8;

	// rr2 status, highest priority first
	parameter logic [2:0] STAT_RX_A  = 3'b110;
	parameter logic [2:0] STAT_TX_A  = 3'b100;
	parameter logic [2:0] STAT_EXT_A = 3'b101;
	parameter logic [2:0] STAT_RX_B  = 3'b010;
	parameter logic [2:0] STAT_TX_B  = 3'b000;
	parameter logic [2:0] STAT_EXT_B = 3'b001;
	parameter logic [2:0] STAT_NONE  = 3'b011;

endpackage

`default_nettype wire

// File: scc_regs.sv
`default_nettype none

module scc_regs (
	input  wire                      clk,
	input  wire                      reset_hw,
	input  scc_pkg::scc_bus_t        i_bus,
	input  wire                      i_rr0_dcd_a,
	input  wire                      i_rr0_dcd_b,
	input  wire                      i_tx_busy,
	input  wire                      i_rx_avail,
	input  wire  [7:0]               i_rx_data,
	input  scc_pkg::scc_pend_t       i_pend,
	input  wire  [2:0]               i_vec_stat,
	output scc_pkg::scc_chan_cfg_t   o_cfg_a,
	output scc_pkg::scc_chan_cfg_t   o_cfg_b,
	output logic                     o_mie,
	output logic                     o_chan_rst_a,
	output logic                     o_chan_rst_b,
	output logic                     o_ext_rst_a,
	output logic                     o_ext_rst_b,
	output logic                     o_tx_ip_rst,
	output logic                     o_tx_wr,
	output logic [7:0]               o_tx_data,
	output logic                     o_rx_read,
	output logic [7:0]               o_rdata
);
	import scc_pkg::*;

	logic [REG_PTR_W-1:0] ptr;       // active pointer
	logic [REG_PTR_W-1:0] ptr_pend;  // takes over once cs drops
	logic [7:0] wr1_a, wr1_b, wr2, wr15_a, wr15_b, data_b;
	logic       wr3_a0, wr3_b0;
	logic [5:0] wr9;
	logic       wreg_a, wreg_b, wreg, wr0_wr, wr9_wr;
	logic       sel_a;
	logic [7:0] wr15_sel, rr0, rr2, rr3, rr15, data_rd;

	assign sel_a  = i_bus.rs[0];
	assign wreg_a = i_bus.cs & i_bus.we & ~i_bus.rs[1] & i_bus.rs[0];
	assign wreg_b = i_bus.cs & i_bus.we & ~i_bus.rs[1] & ~i_bus.rs[0];
	assign wreg   = wreg_a | wreg_b;
	assign wr0_wr = wreg & (ptr == REG_WR0);
	assign wr9_wr = wreg & (ptr == REG_WR9);

	// wr9 soft resets, full hits both channels
	assign o_chan_rst_a = wr9_wr & (i_bus.wdata[7:6] == RST_CHAN_A || i_bus.wdata[7:6] == RST_FULL);
	assign o_chan_rst_b = wr9_wr & (i_bus.wdata[7:6] == RST_CHAN_B || i_bus.wdata[7:6] == RST_FULL);
	assign o_ext_rst_a  = wreg_a & (ptr == REG_WR0) & (i_bus.wdata[5:3] == CMD_RESET_EXT);
	assign o_ext_rst_b  = wreg_b & (ptr == REG_WR0) & (i_bus.wdata[5:3] == CMD_RESET_EXT);
	assign o_tx_ip_rst  = wreg_a & (ptr == REG_WR0) & (i_bus.wdata[5:3] == CMD_RESET_TX_IP);
	assign o_rx_read    = i_bus.cs & ~i_bus.we & i_bus.rs[1] & i_bus.rs[0];
	assign o_mie        = wr9[3];

	assign o_cfg_a = '{wr1: wr1_a, rx_en: wr3_a0, wr15: wr15_a};
	assign o_cfg_b = '{wr1: wr1_b, rx_en: wr3_b0, wr15: wr15_b};

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			ptr      <= '0;
			ptr_pend <= '0;
			wr1_a    <= 8'h00;
			wr1_b    <= 8'h00;
			wr2      <= 8'h00;
			wr3_a0   <= 1'b0;
			wr3_b0   <= 1'b0;
			wr9      <= 6'h00;
			wr15_a   <= WR15_RESET;
			wr15_b   <= WR15_RESET;
			o_tx_wr  <= 1'b0;
		end else begin
			o_tx_wr <= i_bus.cs & i_bus.we & i_bus.rs[1] & i_bus.rs[0]; // data a write
			if (!i_bus.cs)
				ptr <= ptr_pend; // change only after the cpu cycle
			if (wr0_wr)
				ptr_pend <= {i_bus.wdata[5:3] == CMD_POINT_HIGH, i_bus.wdata[2:0]};
			else if (i_bus.cs)
				ptr_pend <= '0; // any other access drops back to wr0
			if (o_chan_rst_a) begin
				wr1_a  <= {2'b00, wr1_a[5], 2'b00, wr1_a[2], 2'b00}; // keeps 5 and 2
				wr15_a <= WR15_RESET;
			end else begin
				if (wreg_a && ptr == REG_WR1) wr1_a <= i_bus.wdata;
				if (wreg_a && ptr == REG_WR15) wr15_a <= i_bus.wdata;
			end
			if (o_chan_rst_b) begin
				wr1_b  <= {2'b00, wr1_b[5], 2'b00, wr1_b[2], 2'b00};
				wr15_b <= WR15_RESET;
			end else begin
				if (wreg_b && ptr == REG_WR1) wr1_b <= i_bus.wdata;
				if (wreg_b && ptr == REG_WR15) wr15_b <= i_bus.wdata;
			end
			if (wreg && ptr == REG_WR2) wr2 <= i_bus.wdata; // shared vector
			if (wreg_a && ptr == REG_WR3) wr3_a0 <= i_bus.wdata[0];
			if (wreg_b && ptr == REG_WR3) wr3_b0 <= i_bus.wdata[0];
			if (wr9_wr) wr9 <= i_bus.wdata[5:0]; // low bits only hw reset
		end
	end

	// data registers
	always_ff @(posedge clk) begin
		if (i_bus.cs && i_bus.we && i_bus.rs[1]) begin
			if (i_bus.rs[0])
				o_tx_data <= i_bus.wdata;
			else
				data_b <= i_bus.wdata; // plain readback
		end
	end

	assign wr15_sel = sel_a ? wr15_a : wr15_b;
	assign data_rd  = sel_a ? i_rx_data : data_b;
	assign rr0  = {1'b0, 1'b1, 2'b00,                  // tx underrun set
		sel_a ? i_rr0_dcd_a : i_rr0_dcd_b,
		sel_a ? ~i_tx_busy : 1'b1,                     // b always empty
		1'b0, sel_a & i_rx_avail};
	assign rr2  = sel_a ? wr2 :
		wr9[4] ? {wr2[7], i_vec_stat[0], i_vec_stat[1], i_vec_stat[2], wr2[3:0]} // status high
		       : {wr2[7:4], i_vec_stat, wr2[0]};
	assign rr3  = sel_a ? {2'b00, i_pend} : 8'h00;  // b side reads 0
	assign rr15 = {wr15_sel[7:3], 1'b0, wr15_sel[1], 1'b0};

	always_comb begin
		o_rdata = 8'h00;
		if (i_bus.rs[1])
			o_rdata = data_rd;
		else if (!ptr[3]) begin
			case (ptr[1:0]) // 0..7 repeat every 4
				2'd0:    o_rdata = rr0;
				2'd1:    o_rdata = 8'h07;  // all sent, residue
				2'd2:    o_rdata = rr2;
				default: o_rdata = rr3;
			endcase
		end else if (ptr == REG_DATA)
			o_rdata = data_rd;
		else if (ptr == REG_RR15B || ptr == REG_WR15)
			o_rdata = rr15;
	end

endmodule

`default_nettype wire

// File: scc_ext_status.sv
`default_nettype none

module scc_ext_status (
	input  wire                    clk,
	input  wire                    reset_hw,
	input  wire                    i_chan_rst,
	input  wire                    i_ext_rst,   // wr0 reset ext/status
	input  wire                    i_dcd,
	input  scc_pkg::scc_chan_cfg_t i_cfg,
	output logic                   o_ext_pend,
	output logic                   o_rr0_dcd
);

	logic dcd_meta, dcd_sync;
	logic latch_open;
	logic dcd_latch;
	logic dcd_chg, do_latch;

	// change seen only when dcd ie set in wr15
	assign dcd_chg  = (dcd_sync != dcd_latch) & i_cfg.wr15[3];
	assign do_latch = latch_open & dcd_chg;
	assign o_rr0_dcd = i_cfg.wr15[3] ? dcd_latch : dcd_sync; // latched or live

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			dcd_meta   <= 1'b0;
			dcd_sync   <= 1'b0;
			latch_open <= 1'b1;
			dcd_latch  <= 1'b0;
			o_ext_pend <= 1'b0;
		end else begin
			dcd_meta <= i_dcd; // 2 stage sync
			dcd_sync <= dcd_meta;
			if (i_chan_rst || i_ext_rst) begin
				latch_open <= 1'b1; // reopen, drop pending
				o_ext_pend <= 1'b0;
				if (i_chan_rst) dcd_latch <= 1'b0;
			end else if (do_latch) begin
				latch_open <= 1'b0;
				dcd_latch  <= dcd_sync;
				if (i_cfg.wr1[0]) o_ext_pend <= 1'b1; // ext int enable
			end
		end
	end

endmodule

`default_nettype wire

// File: scc_irq.sv
`default_nettype none

module scc_irq (
	input  wire                    clk,
	input  wire                    reset_hw,
	input  wire                    i_chan_rst_a,
	input  scc_pkg::scc_chan_cfg_t i_cfg_a,
	input  wire                    i_mie,
	input  wire                    i_ext_pend_a,
	input  wire                    i_ext_pend_b,
	input  wire                    i_tx_busy,
	input  wire                    i_tx_ip_rst,
	input  wire                    i_tx_wr,
	input  wire                    i_rx_valid,
	input  wire  [7:0]             i_rx_data,
	input  wire                    i_rx_read,
	output logic                   o_rx_avail,
	output logic [7:0]             o_rx_data,
	output scc_pkg::scc_pend_t     o_pend,
	output logic [2:0]             o_vec_stat,
	output logic                   o_irq_n
);
	import scc_pkg::*;

	logic tx_busy_q;
	logic tx_pend;
	logic rx_pend;

	// rx int mode: exactly one of wr1 bits 4,3
	assign rx_pend = o_rx_avail & (i_cfg_a.wr1[4] ^ i_cfg_a.wr1[3]) & i_cfg_a.rx_en;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			tx_busy_q  <= 1'b0;
			tx_pend    <= 1'b0;
			o_rx_avail <= 1'b0;
		end else begin
			tx_busy_q <= i_tx_busy;
			if (i_chan_rst_a || i_tx_ip_rst || i_tx_wr)
				tx_pend <= 1'b0;
			else if (tx_busy_q && !i_tx_busy && i_cfg_a.wr1[1])
				tx_pend <= 1'b1; // frame just ended
			if (i_chan_rst_a)
				o_rx_avail <= 1'b0;
			else if (i_rx_valid)
				o_rx_avail <= 1'b1; // new byte wins over a read
			else if (i_rx_read)
				o_rx_avail <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rx_valid) o_rx_data <= i_rx_data; // overwrites unread byte
	end

	// no rx/tx on channel b
	assign o_pend = '{rx_a: rx_pend, tx_a: tx_pend, ext_a: i_ext_pend_a,
		rx_b: 1'b0, tx_b: 1'b0, ext_b: i_ext_pend_b};

	assign o_vec_stat = o_pend.rx_a  ? STAT_RX_A  :
	                    o_pend.tx_a  ? STAT_TX_A  :
	                    o_pend.ext_a ? STAT_EXT_A :
	                    o_pend.rx_b  ? STAT_RX_B  :
	                    o_pend.tx_b  ? STAT_TX_B  :
	                    o_pend.ext_b ? STAT_EXT_B : STAT_NONE;

	assign o_irq_n = ~(i_mie & (|o_pend)); // wr9 mie gates everything

endmodule

`default_nettype wire

// File: scc_uart_tx.sv
`default_nettype none

module scc_uart_tx #(
	parameter int CLKS_PER_BIT = 282
) (
	input  wire        clk,
	input  wire        reset_hw,
	input  wire        i_chan_rst,
	input  wire        i_wr,
	input  wire  [7:0] i_data,
	output logic       o_txd,
	output logic       o_busy
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_cnt;   // bits already on the line after start
	logic [8:0]       shreg;     // stop + data, lsb out first
	logic             baud_tick;
	logic             load;

	assign baud_tick = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign load      = i_wr & ~o_busy; // write while busy is dropped

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_txd    <= 1'b1; // idle mark
			o_busy   <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= 4'd0;
		end else if (i_chan_rst) begin
			o_txd  <= 1'b1;
			o_busy <= 1'b0;
		end else if (load) begin
			o_txd    <= 1'b0; // start bit
			o_busy   <= 1'b1;
			baud_cnt <= '0;
			bit_cnt  <= 4'd0;
		end else if (o_busy) begin
			baud_cnt <= baud_tick ? '0 : baud_cnt + 1'b1;
			if (baud_tick) begin
				if (bit_cnt == 4'd9)
					o_busy <= 1'b0; // stop bit done
				else begin
					o_txd   <= shreg[0];
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			shreg <= {1'b1, i_data};
		else if (o_busy && baud_tick)
			shreg <= {1'b1, shreg[8:1]};
	end

endmodule

`default_nettype wire

// File: scc_uart_rx.sv
`default_nettype none

module scc_uart_rx #(
	parameter int CLKS_PER_BIT = 282
) (
	input  wire        clk,
	input  wire        reset_hw,
	input  wire        i_chan_rst,
	input  wire        i_rxd,
	output logic       o_valid,
	output logic [7:0] o_data
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t        state;
	logic             rxd_meta, rxd_sync;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       shreg;
	logic             half_tick, full_tick;

	assign half_tick = (baud_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)); // middle of start
	assign full_tick = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign o_data    = shreg; // complete when o_valid pulses

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= 3'd0;
			o_valid  <= 1'b0;
		end else begin
			rxd_meta <= i_rxd;
			rxd_sync <= rxd_meta;
			o_valid  <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;
			if (i_chan_rst)
				state <= RX_IDLE;
			else begin
				case (state)
					RX_IDLE: begin
						baud_cnt <= '0;
						if (!rxd_sync) state <= RX_START; // falling edge
					end
					RX_START: if (half_tick) begin
						baud_cnt <= '0;
						bit_cnt  <= 3'd0;
						state    <= rxd_sync ? RX_IDLE : RX_DATA; // glitch back to idle
					end
					RX_DATA: if (full_tick) begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) state <= RX_STOP;
					end
					default: if (full_tick) begin
						o_valid <= rxd_sync; // bad stop bit, frame dropped
						state   <= RX_IDLE;
					end
				endcase
			end
		end
	end

	// mid-bit sample, lsb first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && full_tick)
			shreg <= {rxd_sync, shreg[7:1]};
	end

endmodule

`default_nettype wire

// File: scc_top.sv
`default_nettype none

module scc_top #(
	parameter int CLKS_PER_BIT = 282
) (
	input  wire               clk,
	input  wire               reset_hw,
	input  scc_pkg::scc_bus_t i_bus,
	output logic [7:0]        o_rdata,
	output logic              o_irq_n,
	input  wire               i_rxd,
	output logic              o_txd,
	input  wire               i_dcd_a,
	input  wire               i_dcd_b
);
	import scc_pkg::*;

	scc_chan_cfg_t cfg_a, cfg_b;
	scc_pend_t     pend;
	logic       mie, chan_rst_a, chan_rst_b, ext_rst_a, ext_rst_b, tx_ip_rst;
	logic       tx_wr, tx_busy, rx_valid, rx_read, rx_avail;
	logic       ext_pend_a, ext_pend_b, rr0_dcd_a, rr0_dcd_b;
	logic [7:0] tx_data, rx_byte, rx_data;
	logic [2:0] vec_stat;

	scc_regs regs_i (
		.clk, .reset_hw, .i_bus,
		.i_rr0_dcd_a(rr0_dcd_a), .i_rr0_dcd_b(rr0_dcd_b), .i_tx_busy(tx_busy),
		.i_rx_avail(rx_avail), .i_rx_data(rx_data), .i_pend(pend), .i_vec_stat(vec_stat),
		.o_cfg_a(cfg_a), .o_cfg_b(cfg_b), .o_mie(mie),
		.o_chan_rst_a(chan_rst_a), .o_chan_rst_b(chan_rst_b),
		.o_ext_rst_a(ext_rst_a), .o_ext_rst_b(ext_rst_b), .o_tx_ip_rst(tx_ip_rst),
		.o_tx_wr(tx_wr), .o_tx_data(tx_data), .o_rx_read(rx_read), .o_rdata);

	// one ext/status block per channel
	scc_ext_status ext_a_i (
		.clk, .reset_hw, .i_chan_rst(chan_rst_a), .i_ext_rst(ext_rst_a), .i_dcd(i_dcd_a),
		.i_cfg(cfg_a), .o_ext_pend(ext_pend_a), .o_rr0_dcd(rr0_dcd_a));

	scc_ext_status ext_b_i (
		.clk, .reset_hw, .i_chan_rst(chan_rst_b), .i_ext_rst(ext_rst_b), .i_dcd(i_dcd_b),
		.i_cfg(cfg_b), .o_ext_pend(ext_pend_b), .o_rr0_dcd(rr0_dcd_b));

	scc_irq irq_i (
		.clk, .reset_hw, .i_chan_rst_a(chan_rst_a), .i_cfg_a(cfg_a), .i_mie(mie),
		.i_ext_pend_a(ext_pend_a), .i_ext_pend_b(ext_pend_b), .i_tx_busy(tx_busy),
		.i_tx_ip_rst(tx_ip_rst), .i_tx_wr(tx_wr), .i_rx_valid(rx_valid),
		.i_rx_data(rx_byte), .i_rx_read(rx_read), .o_rx_avail(rx_avail),
		.o_rx_data(rx_data), .o_pend(pend), .o_vec_stat(vec_stat), .o_irq_n);

	// channel a uart only
	scc_uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
		.clk, .reset_hw, .i_chan_rst(chan_rst_a), .i_wr(tx_wr), .i_data(tx_data),
		.o_txd, .o_busy(tx_busy));

	scc_uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
		.clk, .reset_hw, .i_chan_rst(chan_rst_a), .i_rxd,
		.o_valid(rx_valid), .o_data(rx_byte));

endmodule

`default_nettype wire

// File: scc_assert.sv
`default_nettype none

module scc_assert (
	input wire                    clk,
	input wire                    reset_hw,
	input wire                    i_mie,
	input scc_pkg::scc_chan_cfg_t i_cfg_a,
	input wire                    i_tx_busy,
	input wire                    i_chan_rst_a,
	input wire                    i_tx_ip_rst,
	input wire                    i_tx_wr,
	input wire                    i_irq_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// mie low masks the output
	a_mie_mask: assert property (@(posedge clk) disable iff (reset_hw)
		!i_mie |-> i_irq_n)
		else $error("irq output active with mie clear");

	// tx frame end with tx ie set pulls the line low one clk later
	a_irq_on: assert property (@(posedge clk) disable iff (reset_hw)
		($fell(i_tx_busy) && i_cfg_a.wr1[1] && !(i_chan_rst_a || i_tx_ip_rst || i_tx_wr))
		##1 i_mie |-> !i_irq_n)
		else $error("irq output inactive after a tx pending bit with mie set");

endmodule

bind scc_irq scc_assert irq_assert_i (
	.clk(clk), .reset_hw(reset_hw), .i_mie(i_mie), .i_cfg_a(i_cfg_a),
	.i_tx_busy(i_tx_busy), .i_chan_rst_a(i_chan_rst_a), .i_tx_ip_rst(i_tx_ip_rst),
	.i_tx_wr(i_tx_wr), .i_irq_n(o_irq_n));

`default_nettype wire

// File: tb_scc.sv
`default_nettype none

module tb_scc;
	timeunit 1ns;
	timeprecision 1ps;

	import scc_pkg::*;

	localparam int CPB = 8;   // baud divider for the run
	localparam int TMO = 400; // poll limit

	logic       clk;
	logic       reset_hw;
	scc_bus_t   bus;
	logic [7:0] rdata;
	logic       irq_n, rxd, txd, dcd_a, dcd_b;
	integer     seed;
	logic [7:0] wr2_val; // last vector written, for rr2 checks

	scc_top #(.CLKS_PER_BIT(CPB)) dut_i (
		.clk, .reset_hw, .i_bus(bus), .o_rdata(rdata), .o_irq_n(irq_n),
		.i_rxd(rxd), .o_txd(txd), .i_dcd_a(dcd_a), .i_dcd_b(dcd_b));

	always #5 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
	endtask

	task automatic check_pend(input string name, input scc_pend_t got, input scc_pend_t exp);
		logic [5:0] g, e;
		g = got;
		e = exp;
		if (g !== e)
			abort_run($sformatf("ERR %s got %h exp %h", name, g, e));
	endtask

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// vector with status code, reversed in 6..4 when wr9 bit 4 set
	function automatic logic [7:0] rr2_expect(input logic [7:0] vec, input logic [2:0] st,
		input logic high);
		if (high)
			return {vec[7], st[0], st[1], st[2], vec[3:0]};
		return {vec[7:4], st, vec[0]};
	endfunction

	// one clk strobe, then an idle clk so the pointer can move
	task automatic bus_write(input logic [1:0] sel, input logic [7:0] data);
		@(posedge clk);
		#1 bus = '{1'b1, 1'b1, sel, data};
		@(posedge clk);
		#1 bus = '0;
	endtask

	task automatic bus_read(input logic [1:0] sel, output logic [7:0] data);
		@(posedge clk);
		#1 bus = '{1'b1, 1'b0, sel, 8'h00};
		@(negedge clk);
		data = rdata; // settled mid cycle
		@(posedge clk);
		#1 bus = '0;
	endtask

	// pointer select through wr0 first, skipped for wr0 itself
	task automatic reg_write(input logic side_a, input logic [3:0] ptr, input logic [7:0] data);
		if (ptr != 4'd0)
			bus_write({1'b0, side_a}, {2'b00, (ptr[3] ? CMD_POINT_HIGH : 3'b000), ptr[2:0]});
		bus_write({1'b0, side_a}, data);
	endtask

	task automatic reg_read(input logic side_a, input logic [3:0] ptr, output logic [7:0] data);
		if (ptr != 4'd0)
			bus_write({1'b0, side_a}, {2'b00, (ptr[3] ? CMD_POINT_HIGH : 3'b000), ptr[2:0]});
		bus_read({1'b0, side_a}, data);
	endtask

	// poll a read register until the masked bits match
	task automatic wait_reg(input logic side_a, input logic [3:0] ptr, input logic [7:0] mask,
		input logic [7:0] val, input string what);
		logic [7:0] r;
		int n;
		n = 0;
		reg_read(side_a, ptr, r);
		while ((r & mask) !== val) begin
			n++;
			if (n > TMO)
				abort_run($sformatf("timeout waiting for %s", what));
			reg_read(side_a, ptr, r);
		end
	endtask

	task automatic check_rr3(input string name, input scc_pend_t exp);
		logic [7:0] r;
		reg_read(1'b1, 4'd3, r);
		check_byte({name, " unused bits"}, {6'd0, r[7:6]}, 8'h00);
		check_pend(name, scc_pend_t'(r[5:0]), exp);
	endtask

	task automatic send_serial(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0}; // stop, data, start
		@(posedge clk);
		for (int i = 0; i < 10; i++) begin
			#1 rxd = frame[i];
			repeat (CPB) @(posedge clk);
		end
		#1 rxd = 1'b1;
	endtask

	// find the start edge, then sample each bit in its middle
	task automatic capture_serial(output logic [7:0] data);
		int n;
		n = 0;
		@(negedge clk);
		while (txd !== 1'b0) begin
			n++;
			if (n > TMO)
				abort_run("timeout waiting for a start bit on txd");
			@(negedge clk);
		end
		repeat (CPB / 2) @(negedge clk);
		check_bit("txd start bit", txd, 1'b0);
		for (int i = 0; i < 8; i++) begin
			repeat (CPB) @(negedge clk);
			data[i] = txd; // lsb first
		end
		repeat (CPB) @(negedge clk);
		check_bit("txd stop bit", txd, 1'b1);
	endtask

	task automatic test_registers();
		logic [7:0] r, v;
		reg_read(1'b1, 4'd15, r);
		check_byte("RR15 after reset", r, 8'hf8 & ~8'h05);
		check_rr3("RR3 after reset", '0);
		reg_read(1'b1, 4'd0, r);
		check_byte("RR0 A after reset", r, 8'h44); // tx empty, bit 6
		wr2_val = rand_byte();
		reg_write(1'b1, 4'd2, wr2_val);
		reg_read(1'b1, 4'd2, r);
		check_byte("WR2 readback", r, wr2_val);
		v = rand_byte();
		reg_write(1'b1, 4'd15, v);
		reg_read(1'b1, 4'd15, r);
		check_byte("RR15 A", r, v & ~8'h05);
		v = rand_byte();
		bus_write(2'b10, v); // data b
		bus_read(2'b10, r);
		check_byte("data B readback", r, v);
	endtask

	task automatic test_transmit();
		logic [7:0] b, got, r;
		scc_pend_t exp;
		reg_write(1'b1, 4'd1, 8'h02); // tx int enable
		reg_write(1'b1, 4'd9, 8'h08); // mie
		b = rand_byte();
		bus_write(2'b11, b);
		fork
			capture_serial(got);
			begin
				bus_read(2'b01, r); // rr0 a while the frame runs
				check_bit("RR0 tx empty in frame", r[2], 1'b0);
			end
		join
		check_byte("txd byte", got, b);
		wait_reg(1'b1, 4'd0, 8'h04, 8'h04, "RR0 tx empty after frame");
		exp = '0;
		exp.tx_a = 1'b1;
		check_rr3("RR3 tx pending", exp);
		check_bit("o_irq_n tx", irq_n, 1'b0);
		reg_write(1'b1, 4'd0, {2'b00, CMD_RESET_TX_IP, 3'b000});
		check_rr3("RR3 after reset tx IP", '0);
		check_bit("o_irq_n after reset tx IP", irq_n, 1'b1);
	endtask

	task automatic test_receive();
		logic [7:0] b, r;
		scc_pend_t exp;
		reg_write(1'b1, 4'd1, 8'h10); // rx int mode, one of bits 4 and 3
		reg_write(1'b1, 4'd3, 8'h01); // rx enable
		reg_write(1'b1, 4'd9, 8'h18); // mie, status high
		b = rand_byte();
		send_serial(b);
		wait_reg(1'b1, 4'd0, 8'h01, 8'h01, "RR0 rx available");
		exp = '0;
		exp.rx_a = 1'b1;
		check_rr3("RR3 rx pending", exp);
		reg_read(1'b0, 4'd2, r);
		check_byte("RR2 B status high", r, rr2_expect(wr2_val, 3'b110, 1'b1));
		reg_write(1'b1, 4'd9, 8'h08); // status low
		reg_read(1'b0, 4'd2, r);
		check_byte("RR2 B status low", r, rr2_expect(wr2_val, 3'b110, 1'b0));
		check_bit("o_irq_n rx", irq_n, 1'b0);
		bus_read(2'b11, r);
		check_byte("rx data", r, b);
		reg_read(1'b1, 4'd0, r);
		check_bit("RR0 rx available after read", r[0], 1'b0);
		check_rr3("RR3 after rx read", '0);
	endtask

	task automatic test_dcd();
		logic [7:0] r;
		scc_pend_t exp;
		reg_write(1'b0, 4'd15, 8'h08); // dcd ie on b
		reg_write(1'b0, 4'd1, 8'h01);  // ext int enable
		@(posedge clk);
		#1 dcd_b = 1'b1;
		wait_reg(1'b1, 4'd3, 8'h01, 8'h01, "RR3 ext B pending");
		reg_read(1'b0, 4'd0, r);
		check_bit("RR0 B dcd latched", r[3], 1'b1);
		@(posedge clk);
		#1 dcd_b = 1'b0;
		repeat (4) @(posedge clk); // sync plus latch
		reg_read(1'b0, 4'd0, r);
		check_bit("RR0 B dcd held", r[3], 1'b1);
		reg_read(1'b0, 4'd2, r);
		check_byte("RR2 B ext status", r, rr2_expect(wr2_val, 3'b001, 1'b0));
		check_bit("o_irq_n ext", irq_n, 1'b0);
		@(posedge clk);
		#1 dcd_b = 1'b1; // back to the latched level
		repeat (4) @(posedge clk);
		reg_write(1'b0, 4'd0, {2'b00, CMD_RESET_EXT, 3'b000});
		exp = '0;
		check_rr3("RR3 after reset ext", exp);
	endtask

	task automatic test_soft_reset();
		logic [7:0] r;
		reg_write(1'b1, 4'd1, 8'h25);  // bits 5, 2 and ext ie
		reg_write(1'b1, 4'd15, 8'h08);
		reg_write(1'b1, 4'd9, 8'h80);  // channel a reset, mie off
		reg_read(1'b1, 4'd15, r);
		check_byte("RR15 after channel reset", r, 8'hf8 & ~8'h05);
		// wr1 bit 0 gone, so the dcd a change latches without pending
		@(posedge clk);
		#1 dcd_a = 1'b1;
		wait_reg(1'b1, 4'd0, 8'h08, 8'h08, "RR0 A dcd latch");
		check_rr3("RR3 after channel reset", '0);
		@(posedge clk);
		#1 dcd_b = 1'b0; // ext b pending with mie off
		wait_reg(1'b1, 4'd3, 8'h01, 8'h01, "RR3 ext B pending");
		check_bit("o_irq_n mie off", irq_n, 1'b1);
		reg_write(1'b1, 4'd9, 8'h08);
		check_bit("o_irq_n mie on", irq_n, 1'b0);
		reg_write(1'b1, 4'd9, 8'h00);
		check_bit("o_irq_n mie off again", irq_n, 1'b1);
	endtask

	initial begin
		clk      = 1'b0;
		reset_hw = 1'b1;
		bus      = '0;
		rxd      = 1'b1; // line idle
		dcd_a    = 1'b0;
		dcd_b    = 1'b0;
		wr2_val  = 8'h00;
		seed     = 32'h1e16_f23e;
		repeat (3) @(posedge clk);
		#1 reset_hw = 1'b0;
		check_bit("o_irq_n after reset", irq_n, 1'b1);
		check_bit("o_txd after reset", txd, 1'b1);
		test_registers();
		test_transmit();
		test_receive();
		test_dcd();
		test_soft_reset();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
scc_pkg.sv
scc_regs.sv
scc_ext_status.sv
scc_irq.sv
scc_uart_tx.sv
scc_uart_rx.sv
scc_top.sv
scc_assert.sv
tb_scc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_scc
FLIST     ?= list.f
BUILD     ?= obj_dir
TSCALE    ?= 1ns/1ps
VFLAGS    ?= --assert --timing --timescale $(TSCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: build
	./$(BUILD)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)
